//--- hw/soc_mem_pkg.sv
`default_nettype none

package soc_mem_pkg;

   // bus word and byte lanes
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // byte address of the whole sram, word address inside it
   localparam int SRAM_ADDR_W = 10;
   localparam int WORD_ADDR_W = SRAM_ADDR_W - 2;

   // program region is the lower half of the memory
   localparam int PROG_WORDS = (2 ** WORD_ADDR_W) / 2;

   // request on either sram port
   // wstrb of all zeros is a read
   typedef struct packed {
      logic                   valid;
      logic [WORD_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
      logic [STRB_W-1:0]      wstrb;
   } mem_req_t;

   // read data comes back one cycle after the request
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
   } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/boot_loader.sv
`timescale 1ns/1ns
`default_nettype none

module boot_loader (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          boot_valid_i,
   input  logic                          boot_last_i,
   input  logic [soc_mem_pkg::DATA_W-1:0] boot_data_i,
   input  soc_mem_pkg::mem_req_t         fetch_req_i,
   output soc_mem_pkg::mem_req_t         i_req_o,
   output logic                          boot_done_o,
   output logic [soc_mem_pkg::WORD_ADDR_W:0] prog_len_o
);
   import soc_mem_pkg::*;

   logic [WORD_ADDR_W:0] cnt_q;
   logic                 done_q;
   logic                 boot_take;
   mem_req_t             boot_req;

   // boot input is only taken until the last word
   assign boot_take = boot_valid_i && !done_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q  <= '0;
         done_q <= 1'b0;
      end else if (boot_take) begin
         cnt_q <= cnt_q + (WORD_ADDR_W + 1)'(1);
         if (boot_last_i) begin
            done_q <= 1'b1;
         end
      end
   end

   // each boot word is a full word write at the running count
   always_comb begin
      boot_req.valid = boot_take;
      boot_req.addr  = cnt_q[WORD_ADDR_W-1:0];
      boot_req.wdata = boot_data_i;
      boot_req.wstrb = '1;
   end

   // port goes over to the fetcher once loading is over
   assign i_req_o     = done_q ? fetch_req_i : boot_req;
   assign boot_done_o = done_q;

   // counter stops once boot is done, so it doubles as the length
   assign prog_len_o = cnt_q;

   a_cnt_in_region: assert property (
      @(posedge clk_i) disable iff (reset_i)
      cnt_q <= (WORD_ADDR_W + 1)'(PROG_WORDS)
   ) else $error("boot word counter ran past the program region");

   // the fetcher must wait for the image to be complete
   a_no_early_fetch: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !done_q |-> !fetch_req_i.valid
   ) else $error("fetch request issued before boot finished");

endmodule

`default_nettype wire

//--- hw/soc_sram.sv
`timescale 1ns/1ns
`default_nettype none

module soc_sram (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  soc_mem_pkg::mem_req_t i_req_i,
   output soc_mem_pkg::mem_rsp_t i_rsp_o,
   input  soc_mem_pkg::mem_req_t d_req_i,
   output soc_mem_pkg::mem_rsp_t d_rsp_o
);
   import soc_mem_pkg::*;

   logic [DATA_W-1:0] mem [0:(2**WORD_ADDR_W)-1];

   logic [DATA_W-1:0] i_rdata_q;
   logic [DATA_W-1:0] d_rdata_q;
   logic              i_rvalid_q;
   logic              d_rvalid_q;
   logic              i_is_read;
   logic              d_is_read;

   assign i_is_read = i_req_i.valid && (i_req_i.wstrb == '0);
   assign d_is_read = d_req_i.valid && (d_req_i.wstrb == '0);

   // both ports in one block
   // read-first on the same port, old contents come back
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (i_req_i.valid && i_req_i.wstrb[b]) begin
            mem[i_req_i.addr][b*8 +: 8] <= i_req_i.wdata[b*8 +: 8];
         end
         if (d_req_i.valid && d_req_i.wstrb[b]) begin
            mem[d_req_i.addr][b*8 +: 8] <= d_req_i.wdata[b*8 +: 8];
         end
      end
      // read data only moves on a valid request
      if (i_req_i.valid) begin
         i_rdata_q <= mem[i_req_i.addr];
      end
      if (d_req_i.valid) begin
         d_rdata_q <= mem[d_req_i.addr];
      end
   end

   // one pulse per read, nothing for writes
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else begin
         i_rvalid_q <= i_is_read;
         d_rvalid_q <= d_is_read;
      end
   end

   assign i_rsp_o.rdata  = i_rdata_q;
   assign i_rsp_o.rvalid = i_rvalid_q;
   assign d_rsp_o.rdata  = d_rdata_q;
   assign d_rsp_o.rvalid = d_rvalid_q;

   // data port writes must stay clear of the word the instruction port touches
   a_no_wr_collision: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (d_req_i.valid && (d_req_i.wstrb != '0) && i_req_i.valid)
         |-> (d_req_i.addr != i_req_i.addr)
   ) else $error("data port write collides with instruction port access");

   a_valid_known: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !$isunknown({i_req_i.valid, d_req_i.valid})
   ) else $error("request valid is unknown after reset");

endmodule

`default_nettype wire

//--- hw/instr_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instr_fetch (
   input  logic                               clk_i,
   input  logic                               reset_i,
   input  logic                               fetch_en_i,
   input  logic                               boot_done_i,
   input  logic [soc_mem_pkg::WORD_ADDR_W:0]  prog_len_i,
   output soc_mem_pkg::mem_req_t              fetch_req_o,
   input  soc_mem_pkg::mem_rsp_t              i_rsp_i,
   output logic                               instr_valid_o,
   output logic [soc_mem_pkg::DATA_W-1:0]     instr_o,
   output logic [soc_mem_pkg::WORD_ADDR_W-1:0] instr_pc_o
);
   import soc_mem_pkg::*;

   logic [WORD_ADDR_W-1:0] pc_q;
   logic [WORD_ADDR_W-1:0] pend_pc_q;
   logic [WORD_ADDR_W:0]   pc_inc;
   logic                   issue;

   assign issue  = fetch_en_i && boot_done_i;
   assign pc_inc = {1'b0, pc_q} + (WORD_ADDR_W + 1)'(1);

   // pc holds while disabled, wraps after the last loaded word
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pc_q <= '0;
      end else if (issue) begin
         if (pc_inc == prog_len_i) begin
            pc_q <= '0;
         end else begin
            pc_q <= pc_inc[WORD_ADDR_W-1:0];
         end
      end
   end

   // address of the read in flight, paired with the data next cycle
   always_ff @(posedge clk_i) begin
      if (issue) begin
         pend_pc_q <= pc_q;
      end
   end

   always_comb begin
      fetch_req_o.valid = issue;
      fetch_req_o.addr  = pc_q;
      fetch_req_o.wdata = '0;
      fetch_req_o.wstrb = '0;
   end

   assign instr_valid_o = i_rsp_i.rvalid;
   assign instr_o       = i_rsp_i.rdata;
   assign instr_pc_o    = pend_pc_q;

endmodule

`default_nettype wire

//--- hw/soc_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_mem_top (
   input  logic                               clk_i,
   input  logic                               reset_i,
   input  logic                               boot_valid_i,
   input  logic                               boot_last_i,
   input  logic [soc_mem_pkg::DATA_W-1:0]     boot_data_i,
   input  logic                               fetch_en_i,
   input  soc_mem_pkg::mem_req_t              d_req_i,
   output soc_mem_pkg::mem_rsp_t              d_rsp_o,
   output logic                               boot_done_o,
   output logic                               instr_valid_o,
   output logic [soc_mem_pkg::DATA_W-1:0]     instr_o,
   output logic [soc_mem_pkg::WORD_ADDR_W-1:0] instr_pc_o
);
   import soc_mem_pkg::*;

   // instruction side
   mem_req_t             fetch_req;
   mem_req_t             i_req;
   mem_rsp_t             i_rsp;
   logic                 boot_done;
   logic [WORD_ADDR_W:0] prog_len;

   boot_loader u_boot_loader (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .boot_valid_i(boot_valid_i),
      .boot_last_i (boot_last_i),
      .boot_data_i (boot_data_i),
      .fetch_req_i (fetch_req),
      .i_req_o     (i_req),
      .boot_done_o (boot_done),
      .prog_len_o  (prog_len)
   );

   // data port runs straight to the load/store bus
   soc_sram u_soc_sram (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .i_req_i(i_req),
      .i_rsp_o(i_rsp),
      .d_req_i(d_req_i),
      .d_rsp_o(d_rsp_o)
   );

   instr_fetch u_instr_fetch (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .fetch_en_i   (fetch_en_i),
      .boot_done_i  (boot_done),
      .prog_len_i   (prog_len),
      .fetch_req_o  (fetch_req),
      .i_rsp_i      (i_rsp),
      .instr_valid_o(instr_valid_o),
      .instr_o      (instr_o),
      .instr_pc_o   (instr_pc_o)
   );

   assign boot_done_o = boot_done;

endmodule

`default_nettype wire

//--- tb/tb_soc_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_mem;
   import soc_mem_pkg::*;

   localparam int PERIOD = 100;
   localparam int DRIVE_DELAY = 10;
   localparam int RESET_CYCLES = 2;
   localparam int MAX_GAP = 3;
   localparam int MAX_BOOT_WORDS = 60;
   localparam int BOOT_CYCLES = MAX_BOOT_WORDS * (MAX_GAP + 1);
   localparam int HOLD_CYCLES = 150;
   localparam int PAUSE_CYCLES = 150;
   localparam int DATA_CYCLES = 200;
   localparam int MIXED_CYCLES = 200;
   localparam int TOTAL_CYCLES = RESET_CYCLES + PROG_WORDS + BOOT_CYCLES + HOLD_CYCLES
                                 + PAUSE_CYCLES + DATA_CYCLES + MIXED_CYCLES + 1;

   logic                   clk_i;
   logic                   reset_i;
   logic                   boot_valid_i;
   logic                   boot_last_i;
   logic [DATA_W-1:0]      boot_data_i;
   logic                   fetch_en_i;
   mem_req_t               d_req_i;
   mem_rsp_t               d_rsp_o;
   logic                   boot_done_o;
   logic                   instr_valid_o;
   logic [DATA_W-1:0]      instr_o;
   logic [WORD_ADDR_W-1:0] instr_pc_o;

   // memory model and what the DUT should show after the next edge
   logic [DATA_W-1:0]      model_mem [0:(2**WORD_ADDR_W)-1];
   logic [DATA_W-1:0]      exp_rdata_q [$];
   int                     boot_cnt;
   int                     model_pc;
   logic                   exp_boot_done;
   logic                   exp_instr_valid;
   logic [WORD_ADDR_W-1:0] exp_pc;
   logic [DATA_W-1:0]      exp_instr;
   logic                   exp_d_rvalid;

   soc_mem_top DUT (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .boot_valid_i (boot_valid_i),
      .boot_last_i  (boot_last_i),
      .boot_data_i  (boot_data_i),
      .fetch_en_i   (fetch_en_i),
      .d_req_i      (d_req_i),
      .d_rsp_o      (d_rsp_o),
      .boot_done_o  (boot_done_o),
      .instr_valid_o(instr_valid_o),
      .instr_o      (instr_o),
      .instr_pc_o   (instr_pc_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(TOTAL_CYCLES * PERIOD * 2);
      $display("watchdog expired before the tests finished");
      $display("Testbench failed");
      $fatal(1, "timeout");
   end

   task automatic check_value(input string name, input logic [DATA_W-1:0] expv,
                              input logic [DATA_W-1:0] gotv);
      assert (gotv === expv) else begin
         $display("ERR %0t %s expected %0h got %0h", $time, name, expv, gotv);
         $display("Testbench failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // outputs are all registered, so they are stable at the drive point
   task automatic wait_and_check();
      logic [DATA_W-1:0] exp_word;
      @(posedge clk_i);
      #DRIVE_DELAY;
      check_value("boot_done_o", DATA_W'(exp_boot_done), DATA_W'(boot_done_o));
      check_value("instr_valid_o", DATA_W'(exp_instr_valid), DATA_W'(instr_valid_o));
      if (exp_instr_valid) begin
         check_value("instr_pc_o", DATA_W'(exp_pc), DATA_W'(instr_pc_o));
         check_value("instr_o", exp_instr, instr_o);
      end
      check_value("d_rsp_o.rvalid", DATA_W'(exp_d_rvalid), DATA_W'(d_rsp_o.rvalid));
      if (exp_d_rvalid) begin
         exp_word = exp_rdata_q.pop_front();
         check_value("d_rsp_o.rdata", exp_word, d_rsp_o.rdata);
      end
   endtask

   task automatic set_fetch_enable(input logic en);
      fetch_en_i = en;
      // a read goes out only once the loader has handed the port over
      if (en && exp_boot_done) begin
         exp_instr_valid = 1'b1;
         exp_pc = WORD_ADDR_W'(model_pc);
         exp_instr = model_mem[WORD_ADDR_W'(model_pc)];
         model_pc = (model_pc + 1 == boot_cnt) ? 0 : model_pc + 1;
      end else begin
         exp_instr_valid = 1'b0;
      end
   endtask

   task automatic load_boot_word(input logic valid, input logic last,
                                 input logic [DATA_W-1:0] data);
      boot_valid_i = valid;
      boot_last_i = last;
      boot_data_i = data;
      // words after the last one are ignored by the loader
      if (valid && !exp_boot_done) begin
         model_mem[WORD_ADDR_W'(boot_cnt)] = data;
         boot_cnt++;
         if (last) begin
            exp_boot_done = 1'b1;
         end
      end
   endtask

   task automatic bus_idle();
      d_req_i = '0;
      exp_d_rvalid = 1'b0;
   endtask

   task automatic bus_write(input logic [WORD_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
      d_req_i.valid = 1'b1;
      d_req_i.addr = addr;
      d_req_i.wdata = data;
      d_req_i.wstrb = strb;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            model_mem[addr][b*8 +: 8] = data[b*8 +: 8];
         end
      end
      exp_d_rvalid = 1'b0;
   endtask

   task automatic bus_read(input logic [WORD_ADDR_W-1:0] addr);
      d_req_i.valid = 1'b1;
      d_req_i.addr = addr;
      d_req_i.wdata = '0;
      d_req_i.wstrb = '0;
      exp_rdata_q.push_back(model_mem[addr]);
      exp_d_rvalid = 1'b1;
   endtask

   // writes stay in the upper half, reads may also look at the program
   task automatic bus_random_op();
      int unsigned op;
      logic [WORD_ADDR_W-1:0] addr;
      op = $urandom % 3;
      addr = WORD_ADDR_W'(PROG_WORDS + ($urandom % PROG_WORDS));
      case (op)
         0: bus_idle();
         1: bus_write(addr, $urandom, STRB_W'(1 + ($urandom % 15)));
         default: begin
            if ($urandom % 4 == 0) begin
               addr = WORD_ADDR_W'($urandom % boot_cnt);
            end
            bus_read(addr);
         end
      endcase
   endtask

   // fetch goes first so it sees boot_done as it stands before this edge
   task automatic step_cycle(input logic fen, input logic bvalid, input logic blast,
                             input logic [DATA_W-1:0] bdata);
      set_fetch_enable(fen);
      load_boot_word(bvalid, blast, bdata);
      wait_and_check();
   endtask

   initial begin
      int len;
      int gap;
      void'($urandom(86));
      reset_i = 1'b1;
      boot_valid_i = 1'b0;
      boot_last_i = 1'b0;
      boot_data_i = '0;
      fetch_en_i = 1'b0;
      d_req_i = '0;
      boot_cnt = 0;
      model_pc = 0;
      exp_boot_done = 1'b0;
      exp_instr_valid = 1'b0;
      exp_pc = '0;
      exp_instr = '0;
      exp_d_rvalid = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      #DRIVE_DELAY;
      reset_i = 1'b0;
      check_value("boot_done_o", '0, DATA_W'(boot_done_o));
      check_value("instr_valid_o", '0, DATA_W'(instr_valid_o));
      check_value("d_rsp_o.rvalid", '0, DATA_W'(d_rsp_o.rvalid));

      // upper half gets known contents over the data bus
      for (int a = 0; a < PROG_WORDS; a++) begin
         bus_write(WORD_ADDR_W'(PROG_WORDS + a), $urandom, '1);
         step_cycle(1'b0, 1'b0, 1'b0, '0);
      end

      // boot image with random gaps between the words
      len = 20 + int'($urandom % 41);
      for (int w = 0; w < len; w++) begin
         gap = int'($urandom % (MAX_GAP + 1));
         repeat (gap) begin
            bus_idle();
            step_cycle(1'b0, 1'b0, 1'b0, '0);
         end
         bus_idle();
         step_cycle(1'b0, 1'b1, w == len - 1, $urandom);
      end

      repeat (HOLD_CYCLES) begin
         bus_idle();
         step_cycle(1'b1, 1'b0, 1'b0, '0);
      end

      // fetch pauses, with stray boot words that must change nothing
      repeat (PAUSE_CYCLES) begin
         bus_idle();
         step_cycle(1'($urandom % 2), 1'($urandom % 2), 1'($urandom % 2), $urandom);
      end

      repeat (DATA_CYCLES) begin
         bus_random_op();
         step_cycle(1'b0, 1'b0, 1'b0, '0);
      end

      repeat (MIXED_CYCLES) begin
         bus_random_op();
         step_cycle(1'($urandom % 2), 1'b0, 1'b0, '0);
      end

      // one quiet cycle for the last responses
      bus_idle();
      step_cycle(1'b0, 1'b0, 1'b0, '0);

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
hw/soc_mem_pkg.sv
hw/boot_loader.sv
hw/soc_sram.sv
hw/instr_fetch.sv
hw/soc_mem_top.sv
tb/tb_soc_mem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_soc_mem -f verilog.f -Mdir obj_dir -o sim \
   && ./obj_dir/sim | tee /dev/stderr | grep -q "Testbench passed" \
   && echo "simulation ok" \
   || { echo "simulation failed"; exit 1; }
